/* hdl/store_issue_pkg.sv */
// Store issue shared sizes, vector types, handshake structs and unit state encoding
package store_issue_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Store address units, also the width of the issue window
    localparam int STORE_NUM    = 2;
    // Dispatch lanes per cycle
    localparam int DISPATCH_NUM = 2;
    // Issue buffer entries and pointer width
    localparam int SQ_DEPTH     = 8;
    localparam int SQ_PTR_W     = 3;
    // Reorder buffer tag and datapath widths
    localparam int ROB_TAG_W    = 5;
    localparam int XLEN         = 32;

    // ==============================
    // Vector types
    // ==============================

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [XLEN-1:0]      addr_t;
    // Base, offset or store datum
    typedef logic [XLEN-1:0]      word_t;

    // ==============================
    // Structs
    // ==============================

    // One store instruction as held in the issue buffer
    typedef struct packed {
        rob_tag_t rob_tag;
        word_t    base;
        word_t    offset;
        word_t    data;
    } is_inst_t;

    // Router to store address unit
    typedef struct packed {
        logic     valid;
        is_inst_t is_inst;
    } ib_fu_t;

    // Store address unit back to router
    typedef struct packed {
        logic ready;
    } fu_ib_t;

    // Outgoing store request toward the memory port
    typedef struct packed {
        addr_t    addr;
        word_t    data;
        rob_tag_t rob_tag;
    } mem_req_t;

    // Store address unit FSM, empty or holding one request
    typedef enum logic {
        SAU_EMPTY = 1'b0,
        SAU_HELD  = 1'b1
    } sau_state_t;

endpackage

/* hdl/ib_store_queue.sv */
// Store issue buffer, circular in-order queue exposing its oldest entries as a pop window
module ib_store_queue (
    input  logic                                                   clk_i,
    input  logic                                                   rst_n_i,
    // Dispatch side, lane 0 is the older lane
    input  logic [store_issue_pkg::DISPATCH_NUM-1:0]               dispatch_valid_i,
    input  store_issue_pkg::is_inst_t [store_issue_pkg::DISPATCH_NUM-1:0] dispatch_inst_i,
    output logic                                                   dispatch_stall_o,
    // Window toward the router, entry 0 is the head
    output store_issue_pkg::is_inst_t [store_issue_pkg::STORE_NUM-1:0] win_inst_o,
    output logic [store_issue_pkg::STORE_NUM-1:0]                  win_valid_o,
    input  logic [store_issue_pkg::STORE_NUM-1:0]                  win_pop_i
);
    import store_issue_pkg::*;

    // ==============================
    // Declarations
    // ==============================

    // Entry storage, payload only
    is_inst_t entry_q [SQ_DEPTH];

    // Read and write pointers, wrap naturally at SQ_DEPTH
    logic [SQ_PTR_W-1:0] head_q;
    logic [SQ_PTR_W-1:0] tail_q;

    // Occupancy, one bit wider than a pointer so a full buffer is visible
    logic [SQ_PTR_W:0]   count_q;
    logic [SQ_PTR_W:0]   free_cnt;

    // Per-cycle push and pop bookkeeping
    logic [DISPATCH_NUM-1:0]               push_en;
    logic [DISPATCH_NUM-1:0][SQ_PTR_W-1:0] push_ptr;
    logic [SQ_PTR_W:0]                     push_cnt;
    logic [SQ_PTR_W:0]                     pop_cnt;

    // Window read pointers
    logic [STORE_NUM-1:0][SQ_PTR_W-1:0]    win_ptr;

    // ==============================
    // Stall
    // ==============================

    // Free slots from the registered count
    assign free_cnt = (SQ_PTR_W+1)'(SQ_DEPTH) - count_q;

    // Raised whenever a full dispatch group might not fit
    assign dispatch_stall_o = (free_cnt < (SQ_PTR_W+1)'(DISPATCH_NUM));

    // Lanes offered during stall are dropped here
    assign push_en = dispatch_stall_o ? '0 : dispatch_valid_i;

    // ==============================
    // Push side
    // ==============================

    // Compact valid lanes in lane order starting at the tail
    always_comb begin
        push_cnt = '0;
        for (int lane = 0; lane < DISPATCH_NUM; lane++) begin
            // Slot for this lane sits after all older valid lanes
            push_ptr[lane] = tail_q + push_cnt[SQ_PTR_W-1:0];
            if (push_en[lane]) begin
                push_cnt = push_cnt + (SQ_PTR_W+1)'(1);
            end
        end
    end

    // Payload write, no reset on the storage
    always_ff @(posedge clk_i) begin
        for (int lane = 0; lane < DISPATCH_NUM; lane++) begin
            if (push_en[lane]) begin
                entry_q[push_ptr[lane]] <= dispatch_inst_i[lane];
            end
        end
    end

    // ==============================
    // Pop side
    // ==============================

    // Pops arrive as a prefix, so counting the bits gives the head advance
    always_comb begin
        pop_cnt = '0;
        for (int idx = 0; idx < STORE_NUM; idx++) begin
            // Only a valid window slot can really retire
            if (win_pop_i[idx] && win_valid_o[idx]) begin
                pop_cnt = pop_cnt + (SQ_PTR_W+1)'(1);
            end
        end
    end

    // Oldest STORE_NUM entries presented from the head
    always_comb begin
        for (int idx = 0; idx < STORE_NUM; idx++) begin
            win_ptr[idx]     = head_q + SQ_PTR_W'(idx);
            win_inst_o[idx]  = entry_q[win_ptr[idx]];
            // Valid is a contiguous prefix by construction
            win_valid_o[idx] = (count_q > (SQ_PTR_W+1)'(idx));
        end
    end

    // ==============================
    // Pointer and count update
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + pop_cnt[SQ_PTR_W-1:0];
            tail_q  <= tail_q + push_cnt[SQ_PTR_W-1:0];
            // Push and pop in the same cycle net out here
            count_q <= count_q + push_cnt - pop_cnt;
        end
    end

endmodule

/* hdl/ib_store_pop_out_router.sv */
// Store pop-out router, hands the oldest valid window entries in order to ready store units
module ib_store_pop_out_router (
    // Window from the issue buffer
    input  store_issue_pkg::is_inst_t [store_issue_pkg::STORE_NUM-1:0] s_data_i,
    input  logic [store_issue_pkg::STORE_NUM-1:0]                  s_valid_i,
    output logic [store_issue_pkg::STORE_NUM-1:0]                  s_ready_o,
    // Store address unit side
    input  store_issue_pkg::fu_ib_t [store_issue_pkg::STORE_NUM-1:0] fu_ib_i,
    output store_issue_pkg::ib_fu_t [store_issue_pkg::STORE_NUM-1:0] ib_fu_o
);
    import store_issue_pkg::*;

    // ==============================
    // Declarations
    // ==============================

    // Ready bits gathered from the units
    logic [STORE_NUM-1:0]                unit_ready;

    // Row per unit, column per window entry
    logic [STORE_NUM-1:0][STORE_NUM-1:0] route_mat;

    // ==============================
    // Route matrix
    // ==============================

    // Walk units in index order with a pointer to the next unclaimed entry
    function automatic logic [STORE_NUM-1:0][STORE_NUM-1:0] build_route(
        input logic [STORE_NUM-1:0] valid,
        input logic [STORE_NUM-1:0] ready
    );
        logic [STORE_NUM-1:0][STORE_NUM-1:0] mat;
        int                                  next_in;
        mat     = '0;
        next_in = 0;
        for (int unit = 0; unit < STORE_NUM; unit++) begin
            // A busy unit is skipped, the entry waits for the next ready one
            if (next_in < STORE_NUM) begin
                if (ready[unit] && valid[next_in]) begin
                    mat[unit][next_in] = 1'b1;
                    next_in++;
                end
            end
        end
        return mat;
    endfunction

    // Gather unit ready levels into one vector
    always_comb begin
        for (int unit = 0; unit < STORE_NUM; unit++) begin
            unit_ready[unit] = fu_ib_i[unit].ready;
        end
    end

    // ==============================
    // Forwarding and pop strobes
    // ==============================

    always_comb begin
        ib_fu_o   = '0;
        s_ready_o = '0;
        route_mat = build_route(s_valid_i, unit_ready);
        for (int unit = 0; unit < STORE_NUM; unit++) begin
            for (int ent = 0; ent < STORE_NUM; ent++) begin
                if (route_mat[unit][ent]) begin
                    ib_fu_o[unit].valid   = 1'b1;
                    ib_fu_o[unit].is_inst = s_data_i[ent];
                    // Consumed entry retires from the buffer on this edge
                    s_ready_o[ent]        = 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/store_addr_unit.sv */
// Store address unit, adds base and offset and holds one memory request under back-pressure
module store_addr_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Router handshake
    input  store_issue_pkg::ib_fu_t   ib_fu_i,
    output store_issue_pkg::fu_ib_t   fu_ib_o,
    // Memory port
    output store_issue_pkg::mem_req_t mem_req_o,
    output logic                      mem_valid_o,
    input  logic                      mem_ready_i
);
    import store_issue_pkg::*;

    // ==============================
    // Declarations
    // ==============================

    sau_state_t state_q;
    sau_state_t state_d;

    // Held request, payload only
    mem_req_t   req_q;

    logic       drain;
    logic       unit_ready;
    logic       accept;

    // ==============================
    // Handshake
    // ==============================

    // Held request leaves on this edge
    assign drain      = (state_q == SAU_HELD) && mem_ready_i;

    // Free now, or free by the edge because the held request transfers
    assign unit_ready = (state_q == SAU_EMPTY) || drain;
    assign accept     = unit_ready && ib_fu_i.valid;

    assign fu_ib_o.ready = unit_ready;

    // ==============================
    // FSM
    // ==============================

    always_comb begin
        state_d = state_q;
        case (state_q)
            SAU_EMPTY: begin
                if (accept) begin
                    state_d = SAU_HELD;
                end
            end
            SAU_HELD: begin
                // Refill in the same cycle as the drain keeps the unit held
                if (drain && !accept) begin
                    state_d = SAU_EMPTY;
                end
            end
            default: begin
                state_d = SAU_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SAU_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // ==============================
    // Address and request register
    // ==============================

    // Address formed on accept, data and tag ride along unchanged
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q.addr    <= ib_fu_i.is_inst.base + ib_fu_i.is_inst.offset;
            req_q.data    <= ib_fu_i.is_inst.data;
            req_q.rob_tag <= ib_fu_i.is_inst.rob_tag;
        end
    end

    assign mem_req_o   = req_q;
    assign mem_valid_o = (state_q == SAU_HELD);

endmodule

/* hdl/store_issue_top.sv */
// Store issue top, buffer feeding the pop-out router and the store address units
module store_issue_top (
    input  logic                                                   clk_i,
    input  logic                                                   rst_n_i,
    // Dispatch
    input  logic [store_issue_pkg::DISPATCH_NUM-1:0]               dispatch_valid_i,
    input  store_issue_pkg::is_inst_t [store_issue_pkg::DISPATCH_NUM-1:0] dispatch_inst_i,
    output logic                                                   dispatch_stall_o,
    // Memory ports, one per store address unit
    output store_issue_pkg::mem_req_t [store_issue_pkg::STORE_NUM-1:0] mem_req_o,
    output logic [store_issue_pkg::STORE_NUM-1:0]                  mem_valid_o,
    input  logic [store_issue_pkg::STORE_NUM-1:0]                  mem_ready_i
);
    import store_issue_pkg::*;

    // ==============================
    // Internal wiring
    // ==============================

    // Buffer window and pop strobes
    is_inst_t [STORE_NUM-1:0] win_inst;
    logic     [STORE_NUM-1:0] win_valid;
    logic     [STORE_NUM-1:0] win_pop;

    // Router to unit and back
    ib_fu_t   [STORE_NUM-1:0] ib_fu;
    fu_ib_t   [STORE_NUM-1:0] fu_ib;

    // ==============================
    // Instances
    // ==============================

    ib_store_queue u_queue (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_inst_i  (dispatch_inst_i),
        .dispatch_stall_o (dispatch_stall_o),
        .win_inst_o       (win_inst),
        .win_valid_o      (win_valid),
        .win_pop_i        (win_pop)
    );

    // Purely combinational, pops land on the same edge as the unit accept
    ib_store_pop_out_router u_router (
        .s_data_i  (win_inst),
        .s_valid_i (win_valid),
        .s_ready_o (win_pop),
        .fu_ib_i   (fu_ib),
        .ib_fu_o   (ib_fu)
    );

    // One store address unit per memory port
    for (genvar unit = 0; unit < STORE_NUM; unit++) begin : g_sau
        store_addr_unit u_sau (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .ib_fu_i     (ib_fu[unit]),
            .fu_ib_o     (fu_ib[unit]),
            .mem_req_o   (mem_req_o[unit]),
            .mem_valid_o (mem_valid_o[unit]),
            .mem_ready_i (mem_ready_i[unit])
        );
    end

endmodule

/* test/store_issue_props.sv */
// Store issue interface checks, bound onto the top level ports
module store_issue_props (
    input logic                                                   clk_i,
    input logic                                                   rst_n_i,
    input logic [store_issue_pkg::DISPATCH_NUM-1:0]               dispatch_valid_i,
    input logic                                                   dispatch_stall_o,
    input store_issue_pkg::mem_req_t [store_issue_pkg::STORE_NUM-1:0] mem_req_o,
    input logic [store_issue_pkg::STORE_NUM-1:0]                  mem_valid_o,
    input logic [store_issue_pkg::STORE_NUM-1:0]                  mem_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import store_issue_pkg::*;

    // Failed assertion count, read by the testbench at the end
    int assert_fail_cnt = 0;

    // ==============================
    // Dispatch side
    // ==============================

    // Sender keeps every lane low while the buffer stalls
    a_no_dispatch_in_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dispatch_stall_o |-> (dispatch_valid_i == '0)
    ) else begin
        $error("dispatch valid high while stall is high");
        assert_fail_cnt++;
    end

    // ==============================
    // Memory side
    // ==============================

    // No request may be offered right after a reset edge
    a_idle_after_reset: assert property (
        @(posedge clk_i)
        !rst_n_i |=> (mem_valid_o == '0)
    ) else begin
        $error("mem_valid_o high in the cycle after reset");
        assert_fail_cnt++;
    end

    // Held request must not change under back-pressure
    for (genvar unit = 0; unit < STORE_NUM; unit++) begin : g_hold
        a_req_stable: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            (mem_valid_o[unit] && !mem_ready_i[unit]) |=> $stable(mem_req_o[unit])
        ) else begin
            $error("mem_req_o[%0d] changed while held", unit);
            assert_fail_cnt++;
        end
    end

endmodule

bind store_issue_top store_issue_props props0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_stall_o (dispatch_stall_o),
    .mem_req_o        (mem_req_o),
    .mem_valid_o      (mem_valid_o),
    .mem_ready_i      (mem_ready_i)
);

/* test/store_issue_tb.sv */
// Store issue testbench, directed dispatch and memory port tests with a transfer scoreboard
module store_issue_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import store_issue_pkg::*;

    // ==============================
    // DUT signals and scoreboard
    // ==============================

    logic                        clk;
    logic                        rst_n;
    logic [DISPATCH_NUM-1:0]     dispatch_valid;
    is_inst_t [DISPATCH_NUM-1:0] dispatch_inst;
    logic                        dispatch_stall;
    mem_req_t [STORE_NUM-1:0]    mem_req;
    logic [STORE_NUM-1:0]        mem_valid;
    logic [STORE_NUM-1:0]        mem_ready;

    // Dispatched stores not yet seen at a memory port, oldest first
    is_inst_t exp_inst[$];
    int       exp_seq[$];
    // Last dispatch number seen per unit
    int       last_seq [STORE_NUM];
    // Set when transfers must leave in exact dispatch order
    bit       strict_order;
    int       seq_num;
    integer   seed;
    int       errors;
    int       num_checks;
    int       num_tests;

    store_issue_top dut0 (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_inst_i  (dispatch_inst),
        .dispatch_stall_o (dispatch_stall),
        .mem_req_o        (mem_req),
        .mem_valid_o      (mem_valid),
        .mem_ready_i      (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        num_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            errors++;
        end
    endtask

    // Match one transfer against the outstanding stores by tag
    task automatic record_transfer(input int unit, input mem_req_t req);
        int    pos;
        addr_t exp_addr;
        pos = -1;
        for (int i = 0; i < exp_inst.size(); i++) begin
            if (pos < 0 && exp_inst[i].rob_tag == req.rob_tag) begin
                pos = i;
            end
        end
        if (pos < 0) begin
            $display("ERROR at %0t ns: unit %0d sent tag %0d, which is not outstanding",
                     $time, unit, req.rob_tag);
            errors++;
        end else begin
            exp_addr = exp_inst[pos].base + exp_inst[pos].offset;
            compare_value($sformatf("mem_req_o[%0d].addr", unit), req.addr, exp_addr);
            compare_value($sformatf("mem_req_o[%0d].data", unit), req.data,
                          exp_inst[pos].data);
            if (strict_order && pos != 0) begin
                $display("ERROR at %0t ns: tag %0d left unit %0d ahead of an older store",
                         $time, req.rob_tag, unit);
                errors++;
            end
            if (exp_seq[pos] <= last_seq[unit]) begin
                $display("ERROR at %0t ns: unit %0d sent stores out of dispatch order",
                         $time, unit);
                errors++;
            end
            last_seq[unit] = exp_seq[pos];
            exp_inst.delete(pos);
            exp_seq.delete(pos);
        end
    endtask

    // Transfer monitor, sees pre-edge values of valid, ready and request
    always @(posedge clk) begin
        if (rst_n) begin
            for (int u = 0; u < STORE_NUM; u++) begin
                if (mem_valid[u] && mem_ready[u]) begin
                    record_transfer(u, mem_req[u]);
                end
            end
        end
    end

    // One dispatch cycle, lanes dropped by the sender while stalled
    task automatic drive_lanes(input logic [DISPATCH_NUM-1:0] lanes);
        logic [DISPATCH_NUM-1:0] use_lanes;
        @(negedge clk);
        use_lanes = dispatch_stall ? '0 : lanes;
        for (int l = 0; l < DISPATCH_NUM; l++) begin
            dispatch_inst[l] = '0;
            if (use_lanes[l]) begin
                dispatch_inst[l].rob_tag = rob_tag_t'(seq_num);
                dispatch_inst[l].base    = $random(seed);
                dispatch_inst[l].offset  = $random(seed);
                dispatch_inst[l].data    = $random(seed);
                exp_inst.push_back(dispatch_inst[l]);
                exp_seq.push_back(seq_num);
                seq_num++;
            end
        end
        dispatch_valid = use_lanes;
    endtask

    task automatic idle_inputs();
        @(negedge clk);
        dispatch_valid = '0;
    endtask

    // Waits until at most target stores remain outstanding
    task automatic wait_outstanding(input int target, input string what);
        int cycles;
        cycles = 0;
        while (exp_inst.size() > target && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_inst.size() > target) begin
            $display("ERROR at %0t ns: %s timed out with %0d stores outstanding",
                     $time, what, exp_inst.size());
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        num_tests++;
        $display("test %-18s %s", name, (errors == err_start) ? "passed" : "failed");
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic reset_values();
        int err_start;
        err_start = errors;
        compare_value("mem_valid_o", 32'(mem_valid), 32'd0);
        compare_value("dispatch_stall_o", 32'(dispatch_stall), 32'd0);
        finish_test("reset_values", err_start);
    endtask

    // All ports ready, random lane patterns
    task automatic program_order();
        int err_start;
        err_start = errors;
        strict_order = 1'b1;
        @(negedge clk);
        mem_ready = '1;
        for (int n = 0; n < 12; n++) begin
            drive_lanes(DISPATCH_NUM'($random(seed)));
        end
        idle_inputs();
        wait_outstanding(0, "program order drain");
        finish_test("program_order", err_start);
    endtask

    // Unit 1 parks one store, unit 0 carries the rest
    task automatic unit_backpressure();
        int err_start;
        err_start = errors;
        strict_order = 1'b0;
        @(negedge clk);
        mem_ready    = '0;
        mem_ready[0] = 1'b1;
        for (int n = 0; n < 10; n++) begin
            drive_lanes('1);
        end
        idle_inputs();
        wait_outstanding(1, "unit 0 drain under back-pressure");
        compare_value("mem_valid_o[1] while held", 32'(mem_valid[1]), 32'd1);
        // The parked store is the oldest one still outstanding
        if (exp_inst.size() == 0) begin
            $display("ERROR at %0t ns: no store left parked at unit 1", $time);
            errors++;
        end else begin
            compare_value("mem_req_o[1].rob_tag while held", 32'(mem_req[1].rob_tag),
                          32'(exp_inst[0].rob_tag));
            compare_value("mem_req_o[1].addr while held", mem_req[1].addr,
                          exp_inst[0].base + exp_inst[0].offset);
        end
        @(negedge clk);
        mem_ready = '1;
        wait_outstanding(0, "back-pressure release drain");
        finish_test("unit_backpressure", err_start);
    endtask

    // Fill buffer and units with every port blocked, then release
    task automatic buffer_stall();
        int err_start;
        int waited;
        err_start    = errors;
        strict_order = 1'b1;
        waited       = 0;
        @(negedge clk);
        mem_ready = '0;
        while (!dispatch_stall && waited < 20) begin
            drive_lanes('1);
            waited++;
        end
        idle_inputs();
        if (!dispatch_stall) begin
            $display("ERROR at %0t ns: dispatch stall never rose", $time);
            errors++;
        end
        compare_value("stores held at stall", 32'(exp_inst.size()),
                      32'(SQ_DEPTH + STORE_NUM));
        repeat (3) @(negedge clk);
        compare_value("dispatch_stall_o while blocked", 32'(dispatch_stall), 32'd1);
        mem_ready = '1;
        wait_outstanding(0, "stall release drain");
        @(negedge clk);
        compare_value("dispatch_stall_o after drain", 32'(dispatch_stall), 32'd0);
        finish_test("buffer_stall", err_start);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        seed           = 94648;
        errors         = 0;
        num_checks     = 0;
        num_tests      = 0;
        seq_num        = 0;
        strict_order   = 1'b1;
        rst_n          = 1'b0;
        dispatch_valid = '0;
        dispatch_inst  = '0;
        mem_ready      = '0;
        for (int u = 0; u < STORE_NUM; u++) begin
            last_seq[u] = -1;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        program_order();
        unit_backpressure();
        buffer_stall();

        // Bound assertion failures count as errors too
        errors = errors + dut0.props0.assert_fail_cnt;
        $display("tests %0d, checks %0d, errors %0d", num_tests, num_checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/store_issue_pkg.sv
hdl/ib_store_queue.sv
hdl/ib_store_pop_out_router.sv
hdl/store_addr_unit.sv
hdl/store_issue_top.sv
test/store_issue_props.sv
test/store_issue_tb.sv

/* run.sh */
#!/bin/sh
# Build the store issue testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module store_issue_tb --Mdir obj_dir -o store_issue_sim \
    -f project.f

./obj_dir/store_issue_sim +verilator+error+limit+100 > sim.log 2>&1 || {
    cat sim.log
    exit 1
}
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
